// File: common/periph_bus_pkg.sv
package periph_bus_pkg;

   // host bus widths
   localparam int BUS_DATA_W = 64;
   localparam int BUS_ADDR_W = 18;
   localparam int BUS_BE_W   = 8;   // one enable per byte lane

   // slot decode on the upper address bits
   localparam int SLOT_LSB  = 15;
   localparam int NUM_SLOTS = 8;
   localparam int SLOT_W    = $clog2(NUM_SLOTS);

   localparam int SLOT_UART = 6;    // serial console

   // one host access, valid for a single cycle while en is high
   typedef struct packed {
      logic                  en;
      logic [BUS_BE_W-1:0]   we;     // any bit set makes it a write
      logic [BUS_ADDR_W-1:0] addr;
      logic [BUS_DATA_W-1:0] wdata;
   } periph_req_t;

endpackage

// File: common/uart_pkg.sv
package uart_pkg;

   // baud divisor, in clock cycles per bit
   localparam int BAUD_W = 16;
   localparam logic [BAUD_W-1:0] UBAUD_DEFAULT = 16'd54;

   // queue sizing
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = 12;   // wraps at 4096

   // register window inside slot 6
   localparam int UART_SEL_BIT = 14;   // clear selects the keyboard half
   localparam int UART_CNT_BIT = 13;   // read: counters instead of status
   localparam int UART_OP_LSB  = 12;   // write op in bits 13:12

   // write operations
   typedef enum logic [1:0] {
      UOP_TX_PUSH = 2'd0,
      UOP_RX_POP  = 2'd1,
      UOP_BAUD    = 2'd2,
      UOP_NONE    = 2'd3
   } uart_op_e;

   // transmit scheduler
   typedef enum logic [2:0] {
      UTX_IDLE,
      UTX_EMPTY,
      UTX_POP,
      UTX_START,
      UTX_INUSE
   } utx_state_e;

   // queue entry, framing error flag above the byte
   typedef struct packed {
      logic       err;
      logic [7:0] data;
   } uart_entry_t;

endpackage

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
   import uart_pkg::*;
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  logic                  push_i,
   input  logic                  pop_i,
   input  uart_entry_t           din_i,
   output uart_entry_t           dout_o,
   output logic                  full_o,
   output logic                  empty_o,
   output logic [FIFO_CNT_W-1:0] push_cnt_o,
   output logic [FIFO_CNT_W-1:0] pop_cnt_o
);

   uart_entry_t           mem [FIFO_DEPTH];
   logic [FIFO_PTR_W:0]   wr_ptr_q;   // extra msb tells full from empty
   logic [FIFO_PTR_W:0]   rd_ptr_q;
   logic                  do_push;
   logic                  do_pop;
   logic [FIFO_CNT_W-1:0] push_cnt_q;
   logic [FIFO_CNT_W-1:0] pop_cnt_q;

   assign empty_o = wr_ptr_q == rd_ptr_q;
   assign full_o  = (wr_ptr_q[FIFO_PTR_W] != rd_ptr_q[FIFO_PTR_W]) &&
                    (wr_ptr_q[FIFO_PTR_W-1:0] == rd_ptr_q[FIFO_PTR_W-1:0]);

   assign do_push = push_i && !full_o;   // dropped when full
   assign do_pop  = pop_i && !empty_o;   // dropped when empty

   assign dout_o     = mem[rd_ptr_q[FIFO_PTR_W-1:0]];   // head visible before pop
   assign push_cnt_o = push_cnt_q;
   assign pop_cnt_o  = pop_cnt_q;

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
         mem[wr_ptr_q[FIFO_PTR_W-1:0]] <= din_i;
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         push_cnt_q <= '0;
         pop_cnt_q  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr_q   <= wr_ptr_q + 1'b1;
            push_cnt_q <= push_cnt_q + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr_q  <= rd_ptr_q + 1'b1;
            pop_cnt_q <= pop_cnt_q + 1'b1;
         end
      end
   end

   // accepted pushes never run more than a full queue ahead of accepted pops
   a_occupancy: assert property (@(posedge msoc_clk) disable iff (!rstn)
      FIFO_CNT_W'(push_cnt_q - pop_cnt_q) <= FIFO_CNT_W'(FIFO_DEPTH));

   // flags follow the running counts and are never set together
   a_full_empty: assert property (@(posedge msoc_clk) disable iff (!rstn)
      (empty_o == (push_cnt_q == pop_cnt_q)) &&
      (full_o == (FIFO_CNT_W'(push_cnt_q - pop_cnt_q) == FIFO_CNT_W'(FIFO_DEPTH))));

endmodule

// File: uart/uart_serial.sv
`timescale 1ns/1ps

module uart_serial
   import uart_pkg::*;
(
   input  logic              msoc_clk,
   input  logic              rstn,
   input  logic [BAUD_W-1:0] baud_i,
   input  logic              tx_start_i,
   input  logic [7:0]        tx_byte_i,
   output logic              tx_busy_o,
   input  logic              rx_i,
   output logic              rx_valid_o,
   output uart_entry_t       rx_entry_o,
   output logic              tx_o
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   logic [2:0]        rx_samp_q;   // last three line samples
   logic              rx_maj;
   logic              rx_maj_q;
   rx_state_e         rx_state_q;
   logic [BAUD_W-1:0] rx_cnt_q;
   logic              rx_tick;
   logic [2:0]        rx_bit_q;
   logic [7:0]        rx_shift_q;
   logic              rx_valid_q;
   uart_entry_t       rx_entry_q;

   logic [BAUD_W-1:0] tx_cnt_q;
   logic              tx_tick;
   logic [3:0]        tx_bits_q;   // bits left after the current one
   logic [8:0]        tx_shift_q;  // data then stop
   logic              tx_busy_q;
   logic              tx_q;

   assign rx_maj = (rx_samp_q[0] & rx_samp_q[1]) |
                   (rx_samp_q[0] & rx_samp_q[2]) |
                   (rx_samp_q[1] & rx_samp_q[2]);

   assign rx_tick    = rx_cnt_q == '0;
   assign rx_valid_o = rx_valid_q;
   assign rx_entry_o = rx_entry_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rx_samp_q  <= 3'b111;   // idle line is high
         rx_maj_q   <= 1'b1;
         rx_state_q <= RX_IDLE;
         rx_cnt_q   <= '0;
         rx_bit_q   <= '0;
         rx_valid_q <= 1'b0;
      end
      else
      begin
         rx_samp_q  <= {rx_samp_q[1:0], rx_i};
         rx_maj_q   <= rx_maj;
         rx_valid_q <= 1'b0;
         if (!rx_tick)
            rx_cnt_q <= rx_cnt_q - 1'b1;
         case (rx_state_q)
            RX_IDLE:
               if (rx_maj_q && !rx_maj)   // falling edge of start bit
               begin
                  rx_cnt_q   <= baud_i >> 1;
                  rx_state_q <= RX_START;
               end
            RX_START:
               if (rx_tick)
               begin
                  if (rx_maj)
                     rx_state_q <= RX_IDLE;   // glitch, not a start bit
                  else
                  begin
                     rx_cnt_q   <= baud_i - 1'b1;
                     rx_bit_q   <= '0;
                     rx_state_q <= RX_DATA;
                  end
               end
            RX_DATA:
               if (rx_tick)
               begin
                  rx_cnt_q <= baud_i - 1'b1;
                  rx_bit_q <= rx_bit_q + 1'b1;
                  if (rx_bit_q == 3'd7)
                     rx_state_q <= RX_STOP;
               end
            RX_STOP:
               if (rx_tick)
               begin
                  rx_valid_q <= 1'b1;
                  rx_state_q <= RX_IDLE;
               end
            default:
               rx_state_q <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (rx_state_q == RX_DATA && rx_tick)
         rx_shift_q <= {rx_maj, rx_shift_q[7:1]};   // lsb arrives first
      if (rx_state_q == RX_STOP && rx_tick)
      begin
         rx_entry_q.err  <= !rx_maj;   // stop bit must be high
         rx_entry_q.data <= rx_shift_q;
      end
   end

   assign tx_tick   = tx_cnt_q == '0;
   assign tx_busy_o = tx_busy_q;
   assign tx_o      = tx_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_busy_q <= 1'b0;
         tx_q      <= 1'b1;
         tx_cnt_q  <= '0;
         tx_bits_q <= '0;
      end
      else if (!tx_busy_q)
      begin
         if (tx_start_i)
         begin
            tx_busy_q <= 1'b1;
            tx_q      <= 1'b0;   // start bit
            tx_cnt_q  <= baud_i - 1'b1;
            tx_bits_q <= 4'd9;
         end
      end
      else if (tx_tick)
      begin
         if (tx_bits_q == '0)
         begin
            tx_busy_q <= 1'b0;
            tx_q      <= 1'b1;
         end
         else
         begin
            tx_q      <= tx_shift_q[0];
            tx_bits_q <= tx_bits_q - 1'b1;
            tx_cnt_q  <= baud_i - 1'b1;
         end
      end
      else
         tx_cnt_q <= tx_cnt_q - 1'b1;
   end

   always_ff @(posedge msoc_clk)
   begin
      if (!tx_busy_q && tx_start_i)
         tx_shift_q <= {1'b1, tx_byte_i};
      else if (tx_busy_q && tx_tick && tx_bits_q != '0)
         tx_shift_q <= {1'b1, tx_shift_q[8:1]};
   end

   a_rx_pulse: assert property (@(posedge msoc_clk) disable iff (!rstn)
      rx_valid_q |=> !rx_valid_q);

endmodule

// File: uart/uart_regs.sv
`timescale 1ns/1ps

module uart_regs
   import periph_bus_pkg::*;
   import uart_pkg::*;
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  periph_req_t           req_i,
   input  logic                  sel_i,
   output logic [BUS_DATA_W-1:0] rdata_o,
   input  logic                  uart_rx_i,
   output logic                  uart_tx_o,
   output logic                  irq_o
);

   logic                  uart_wr;
   uart_op_e              op;
   logic [BAUD_W-1:0]     baud_q;
   utx_state_e            utx_q;
   utx_state_e            utx_d;
   logic [7:0]            tx_byte_q;
   logic                  tx_start;
   logic                  tx_busy;
   logic                  rx_valid;
   uart_entry_t           rx_entry;

   logic                  tx_push;
   logic                  tx_pop;
   uart_entry_t           tx_din;
   uart_entry_t           tx_head;
   logic                  tx_full;
   logic                  tx_empty;
   logic [FIFO_CNT_W-1:0] tx_push_cnt;
   logic [FIFO_CNT_W-1:0] tx_pop_cnt;

   logic                  rx_pop;
   uart_entry_t           rx_head;
   logic                  rx_full;
   logic                  rx_empty;
   logic [FIFO_CNT_W-1:0] rx_push_cnt;
   logic [FIFO_CNT_W-1:0] rx_pop_cnt;

   assign uart_wr = sel_i && (|req_i.we) && req_i.addr[UART_SEL_BIT];
   assign op      = uart_op_e'(req_i.addr[UART_OP_LSB +: 2]);
   assign tx_push = uart_wr && op == UOP_TX_PUSH;
   assign rx_pop  = uart_wr && op == UOP_RX_POP;
   assign tx_din  = '{err: 1'b0, data: req_i.wdata[7:0]};

   assign tx_pop   = utx_q == UTX_POP;
   assign tx_start = utx_q == UTX_START;
   assign irq_o    = !rx_empty;   // something waiting to be read

   always_comb
   begin
      utx_d = utx_q;
      case (utx_q)
         UTX_IDLE:  utx_d = UTX_EMPTY;
         UTX_EMPTY: if (!tx_empty) utx_d = UTX_POP;
         UTX_POP:   utx_d = UTX_START;
         UTX_START: utx_d = UTX_INUSE;
         UTX_INUSE: if (!tx_busy) utx_d = UTX_IDLE;
         default:   utx_d = UTX_IDLE;
      endcase
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         utx_q  <= UTX_IDLE;
         baud_q <= UBAUD_DEFAULT;
      end
      else
      begin
         utx_q <= utx_d;
         if (uart_wr && op == UOP_BAUD)
            baud_q <= req_i.wdata[BAUD_W-1:0];
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (tx_pop)
         tx_byte_q <= tx_head.data;   // held while the frame is sent
   end

   always_comb
   begin
      rdata_o = '0;
      if (req_i.addr[UART_SEL_BIT])
      begin
         if (req_i.addr[UART_CNT_BIT])
            rdata_o = {4'b0, tx_push_cnt, 4'b0, tx_pop_cnt,
                       4'b0, rx_push_cnt, 4'b0, rx_pop_cnt};
         else
            rdata_o = {52'b0, rx_full, tx_full, rx_empty, rx_head};
      end
   end

   sync_fifo tx_fifo (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .push_i     (tx_push),
      .pop_i      (tx_pop),
      .din_i      (tx_din),
      .dout_o     (tx_head),
      .full_o     (tx_full),
      .empty_o    (tx_empty),
      .push_cnt_o (tx_push_cnt),
      .pop_cnt_o  (tx_pop_cnt)
   );

   sync_fifo rx_fifo (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .push_i     (rx_valid),
      .pop_i      (rx_pop),
      .din_i      (rx_entry),
      .dout_o     (rx_head),
      .full_o     (rx_full),
      .empty_o    (rx_empty),
      .push_cnt_o (rx_push_cnt),
      .pop_cnt_o  (rx_pop_cnt)
   );

   uart_serial uart_serial_i (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_i     (baud_q),
      .tx_start_i (tx_start),
      .tx_byte_i  (tx_byte_q),
      .tx_busy_o  (tx_busy),
      .rx_i       (uart_rx_i),
      .rx_valid_o (rx_valid),
      .rx_entry_o (rx_entry),
      .tx_o       (uart_tx_o)
   );

   // scheduler only starts a frame once the engine has gone idle
   a_tx_start: assert property (@(posedge msoc_clk) disable iff (!rstn)
      tx_start |-> !tx_busy);

endmodule

// File: logic/periph_soc.sv
`timescale 1ns/1ps

module periph_soc
   import periph_bus_pkg::*;
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  periph_req_t           hid_req_i,
   output logic [BUS_DATA_W-1:0] hid_rddata_o,
   input  logic                  uart_rx_i,
   output logic                  uart_tx_o,
   output logic                  uart_irq_o
);

   logic [SLOT_W-1:0]     slot;
   logic [NUM_SLOTS-1:0]  slot_hit;
   logic [BUS_DATA_W-1:0] slot_rdata [NUM_SLOTS];
   logic                  uart_sel;
   logic [BUS_DATA_W-1:0] uart_rdata;

   assign slot     = hid_req_i.addr[SLOT_LSB +: SLOT_W];
   assign uart_sel = hid_req_i.en && slot_hit[SLOT_UART];

   // only slot 6 is populated, the rest read as zero
   always_comb
   begin
      for (int i = 0; i < NUM_SLOTS; i++)
      begin
         slot_hit[i]   = slot == SLOT_W'(i);
         slot_rdata[i] = (i == SLOT_UART) ? uart_rdata : '0;
      end
   end

   always_comb
   begin
      hid_rddata_o = '0;
      for (int i = 0; i < NUM_SLOTS; i++)
      begin
         if (slot_hit[i])
            hid_rddata_o = hid_rddata_o | slot_rdata[i];
      end
   end

   uart_regs uart_regs_i (
      .msoc_clk  (msoc_clk),
      .rstn      (rstn),
      .req_i     (hid_req_i),
      .sel_i     (uart_sel),
      .rdata_o   (uart_rdata),
      .uart_rx_i (uart_rx_i),
      .uart_tx_o (uart_tx_o),
      .irq_o     (uart_irq_o)
   );

endmodule

// File: tb/uart_line_model.sv
`timescale 1ns/1ps

module uart_line_model
(
   input  logic        msoc_clk,
   input  int unsigned bit_cycles_i,   // clock cycles per bit
   input  logic        tx_i,           // DUT transmit line
   output logic        rx_o            // DUT receive line
);

   logic [8:0] frames [$];   // decoded frames, stop bit above the byte
   logic [7:0] mon_data;
   int         mon_bit;

   initial
   begin
      rx_o = 1'b1;   // idle line
   end

   // one 8N1 frame, then one idle bit
   task automatic send_frame(input logic [7:0] data, input logic bad_stop);
      int i;
      @(negedge msoc_clk);
      rx_o = 1'b0;   // start bit
      repeat (bit_cycles_i) @(negedge msoc_clk);
      for (i = 0; i < 8; i++)
      begin
         rx_o = data[i];   // lsb first
         repeat (bit_cycles_i) @(negedge msoc_clk);
      end
      rx_o = !bad_stop;
      repeat (bit_cycles_i) @(negedge msoc_clk);
      rx_o = 1'b1;
      repeat (bit_cycles_i) @(negedge msoc_clk);
   endtask

   task automatic take_frame(input int unsigned max_cycles, output logic [8:0] frame,
                             output logic found);
      int unsigned waited;
      found  = 1'b0;
      frame  = '0;
      waited = 0;
      while (!found && waited < max_cycles)
      begin
         if (frames.size() > 0)
         begin
            frame = frames.pop_front();
            found = 1'b1;
         end
         else
         begin
            @(negedge msoc_clk);
            waited++;
         end
      end
   endtask

   // monitor samples each bit near its middle
   initial
   begin
      forever
      begin
         @(negedge msoc_clk);
         if (tx_i === 1'b0)
         begin
            repeat (bit_cycles_i / 2) @(negedge msoc_clk);
            for (mon_bit = 0; mon_bit < 8; mon_bit++)
            begin
               repeat (bit_cycles_i) @(negedge msoc_clk);
               mon_data[mon_bit] = tx_i;
            end
            repeat (bit_cycles_i) @(negedge msoc_clk);
            frames.push_back({tx_i, mon_data});   // stop sampled mid bit
         end
      end
   end

endmodule

// File: tb/tb_periph_soc.sv
`timescale 1ns/1ps

module tb_periph_soc
   import periph_bus_pkg::*;
   import uart_pkg::*;
;

   localparam int CLK_PERIOD = 40;
   localparam int BAUD_DIV   = 8;    // only divisor used for frames
   localparam int NUM_TX     = 10;

   typedef enum logic [1:0] {
      STEP_WRITE,
      STEP_READ,
      STEP_SEND,
      STEP_EXPECT
   } step_kind_e;

   typedef struct packed {
      step_kind_e            kind;
      logic [BUS_ADDR_W-1:0] addr;
      logic [BUS_DATA_W-1:0] data;
      logic                  bad_stop;
      logic [BUS_DATA_W-1:0] expected;
   } step_t;

   logic                  msoc_clk;
   logic                  rstn;
   periph_req_t           hid_req;
   logic [BUS_DATA_W-1:0] hid_rddata;
   logic                  uart_rx;
   logic                  uart_tx;
   logic                  uart_irq;

   step_t      steps [$];
   logic [8:0] rx_model [$];   // expected receive queue contents
   int         tx_push_n;
   int         tx_pop_n;
   int         rx_push_n;
   int         rx_pop_n;
   int         errors;
   integer     seed;
   logic       table_ready;

   periph_soc periph_soc_i (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_req_i    (hid_req),
      .hid_rddata_o (hid_rddata),
      .uart_rx_i    (uart_rx),
      .uart_tx_o    (uart_tx),
      .uart_irq_o   (uart_irq)
   );

   uart_line_model line_model (
      .msoc_clk     (msoc_clk),
      .bit_cycles_i (BAUD_DIV),
      .tx_i         (uart_tx),
      .rx_o         (uart_rx)
   );

   always #(CLK_PERIOD / 2) msoc_clk = ~msoc_clk;

   function automatic logic [BUS_ADDR_W-1:0] uart_addr(input int slot, input logic sel,
                                                       input logic [1:0] low);
      return {slot[2:0], sel, low, 12'h000};
   endfunction

   function automatic logic status_window(input logic [BUS_ADDR_W-1:0] addr);
      return addr[17:15] == 3'(SLOT_UART) && addr[14] && !addr[13];
   endfunction

   function automatic logic [BUS_DATA_W-1:0] status_word();
      logic [BUS_DATA_W-1:0] w;
      w = '0;
      if (rx_model.size() > 0)
         w[8:0] = rx_model[0];
      w[9]  = rx_model.size() == 0;
      w[11] = rx_model.size() == FIFO_DEPTH;   // tx queue never fills here
      return w;
   endfunction

   function automatic logic [BUS_DATA_W-1:0] counters_word();
      logic [BUS_DATA_W-1:0] w;
      w        = '0;
      w[11:0]  = rx_pop_n[11:0];
      w[27:16] = rx_push_n[11:0];
      w[43:32] = tx_pop_n[11:0];
      w[59:48] = tx_push_n[11:0];
      return w;
   endfunction

   task automatic append_step(input step_kind_e kind, input logic [BUS_ADDR_W-1:0] addr,
                              input logic [BUS_DATA_W-1:0] data, input logic bad_stop,
                              input logic [BUS_DATA_W-1:0] expected);
      step_t s;
      s.kind     = kind;
      s.addr     = addr;
      s.data     = data;
      s.bad_stop = bad_stop;
      s.expected = expected;
      steps.push_back(s);
   endtask

   task automatic write_reg(input logic [BUS_ADDR_W-1:0] addr, input logic [BUS_DATA_W-1:0] data);
      append_step(STEP_WRITE, addr, data, 1'b0, '0);
   endtask

   task automatic check_read(input logic [BUS_ADDR_W-1:0] addr,
                             input logic [BUS_DATA_W-1:0] expected);
      append_step(STEP_READ, addr, '0, 1'b0, expected);
   endtask

   task automatic push_tx(input logic [7:0] b);
      append_step(STEP_WRITE, uart_addr(SLOT_UART, 1'b1, UOP_TX_PUSH), 64'(b), 1'b0, '0);
      tx_push_n++;
   endtask

   task automatic expect_byte(input logic [7:0] b);
      append_step(STEP_EXPECT, '0, '0, 1'b0, 64'({1'b1, b}));
      tx_pop_n++;   // frame on the line means it left the queue
   endtask

   task automatic send_byte(input logic [7:0] b, input logic bad_stop);
      append_step(STEP_SEND, '0, 64'(b), bad_stop, '0);
      if (rx_model.size() < FIFO_DEPTH)
      begin
         rx_model.push_back({bad_stop, b});
         rx_push_n++;
      end
   endtask

   task automatic pop_rx();
      append_step(STEP_WRITE, uart_addr(SLOT_UART, 1'b1, UOP_RX_POP), '0, 1'b0, '0);
      if (rx_model.size() > 0)
      begin
         void'(rx_model.pop_front());
         rx_pop_n++;
      end
   endtask

   task automatic build_table();
      logic [BUS_ADDR_W-1:0] st_addr;
      logic [BUS_ADDR_W-1:0] cnt_addr;
      logic [31:0]           rnd;
      logic [7:0]            bytes [$];
      int                    i;
      st_addr  = uart_addr(SLOT_UART, 1'b1, 2'b00);
      cnt_addr = uart_addr(SLOT_UART, 1'b1, 2'b10);
      check_read(st_addr, status_word());
      check_read(cnt_addr, counters_word());
      // transmit
      write_reg(uart_addr(SLOT_UART, 1'b1, UOP_BAUD), 64'(BAUD_DIV));
      for (i = 0; i < NUM_TX; i++)
      begin
         rnd = $random(seed);
         bytes.push_back(rnd[7:0]);
         push_tx(rnd[7:0]);
      end
      for (i = 0; i < NUM_TX; i++)
         expect_byte(bytes[i]);
      check_read(cnt_addr, counters_word());
      // receive
      bytes.delete();
      for (i = 0; i < 4; i++)
      begin
         rnd = $random(seed);
         bytes.push_back(rnd[7:0]);
      end
      send_byte(bytes[0], 1'b0);
      check_read(st_addr, status_word());   // irq up after the first byte
      for (i = 1; i < 4; i++)
         send_byte(bytes[i], 1'b0);
      for (i = 0; i < 4; i++)
      begin
         check_read(st_addr, status_word());
         pop_rx();
      end
      check_read(st_addr, status_word());
      check_read(cnt_addr, counters_word());
      // framing error
      rnd = $random(seed);
      send_byte(rnd[7:0], 1'b1);
      check_read(st_addr, status_word());
      pop_rx();
      check_read(st_addr, status_word());
      // overflow, last three frames get dropped
      for (i = 0; i < FIFO_DEPTH + 3; i++)
      begin
         rnd = $random(seed);
         send_byte(rnd[7:0], 1'b0);
      end
      check_read(st_addr, status_word());
      check_read(cnt_addr, counters_word());
      for (i = 0; i < FIFO_DEPTH; i++)
      begin
         check_read(st_addr, status_word());
         pop_rx();
      end
      check_read(st_addr, status_word());
      check_read(cnt_addr, counters_word());
      // decode
      for (i = 0; i < NUM_SLOTS; i++)
      begin
         if (i != SLOT_UART)
         begin
            check_read(uart_addr(i, 1'b1, 2'b00), '0);
            check_read(uart_addr(i, 1'b1, 2'b10), '0);
         end
      end
      check_read(uart_addr(SLOT_UART, 1'b0, 2'b00), '0);
      check_read(uart_addr(SLOT_UART, 1'b0, 2'b10), '0);
      write_reg(uart_addr(3, 1'b1, UOP_TX_PUSH), 64'h5a);
      check_read(cnt_addr, counters_word());
   endtask

   task automatic run_step(input step_t s);
      logic [BUS_DATA_W-1:0] mask;
      logic [8:0]            frame;
      logic                  found;
      case (s.kind)
         STEP_WRITE:
         begin
            @(negedge msoc_clk);
            hid_req.en    = 1'b1;
            hid_req.we    = 8'h01;
            hid_req.addr  = s.addr;
            hid_req.wdata = s.data;
            @(negedge msoc_clk);
            hid_req = '0;
         end
         STEP_READ:
         begin
            @(negedge msoc_clk);
            hid_req.en   = 1'b1;
            hid_req.addr = s.addr;
            #(CLK_PERIOD / 4);   // mid low phase, read data settled
            mask = '1;
            if (status_window(s.addr) && s.expected[9])
               mask[8:0] = '0;   // head is stale while empty
            if ((hid_rddata & mask) !== (s.expected & mask))
            begin
               errors++;
               $display("Error at %0t: read of 0x%05h gave 0x%016h, expected 0x%016h",
                        $time, s.addr, hid_rddata, s.expected);
            end
            if (status_window(s.addr) && (uart_irq !== !s.expected[9]))
            begin
               errors++;
               $display("Error at %0t: uart_irq_o is %b, expected %b",
                        $time, uart_irq, !s.expected[9]);
            end
            @(negedge msoc_clk);
            hid_req = '0;
         end
         STEP_SEND:
            line_model.send_frame(s.data[7:0], s.bad_stop);
         STEP_EXPECT:
         begin
            line_model.take_frame(12 * BAUD_DIV, frame, found);
            if (!found)
            begin
               errors++;
               $display("No frame appeared on uart_tx_o by %0t, byte 0x%02h was due",
                        $time, s.expected[7:0]);
            end
            else if (frame !== s.expected[8:0])
            begin
               errors++;
               $display("Error at %0t: frame 0x%03h on uart_tx_o, expected 0x%03h",
                        $time, frame, s.expected[8:0]);
            end
         end
         default:
            ;
      endcase
   endtask

   initial
   begin
      msoc_clk    = 1'b0;
      rstn        = 1'b0;
      hid_req     = '0;
      errors      = 0;
      tx_push_n   = 0;
      tx_pop_n    = 0;
      rx_push_n   = 0;
      rx_pop_n    = 0;
      seed        = 32'h5e89f74b;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (16) @(negedge msoc_clk);
      rstn = 1'b1;
      @(negedge msoc_clk);
      if (uart_tx !== 1'b1)
      begin
         errors++;
         $display("Error at %0t: uart_tx_o is %b after reset, expected 1", $time, uart_tx);
      end
      if (uart_irq !== 1'b0)
      begin
         errors++;
         $display("Error at %0t: uart_irq_o is %b after reset, expected 0", $time, uart_irq);
      end
      foreach (steps[i])
         run_step(steps[i]);
      $display("%0d errors over %0d steps", errors, steps.size());
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // room for 12 bit times per step, doubled
   initial
   begin
      wait (table_ready);
      #(steps.size() * 12 * BAUD_DIV * CLK_PERIOD * 2);
      $display("The watchdog stopped the run at %0t before all steps finished", $time);
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: all.f
common/periph_bus_pkg.sv
common/uart_pkg.sv
logic/sync_fifo.sv
uart/uart_serial.sv
uart/uart_regs.sv
logic/periph_soc.sv
tb/uart_line_model.sv
tb/tb_periph_soc.sv

// File: Bender.yml
package:
  name: periph_soc

sources:
  - common/periph_bus_pkg.sv
  - common/uart_pkg.sv
  - logic/sync_fifo.sv
  - uart/uart_serial.sv
  - uart/uart_regs.sv
  - logic/periph_soc.sv
  - target: test
    files:
      - tb/uart_line_model.sv
      - tb/tb_periph_soc.sv
